/* deser_pkg.sv */
// Shared widths and types for the flit deserializer.
// The widths are fixed here, so the push-to-pop ratio is always 4.
// pop_width must be an exact multiple of push_width.

package deser_pkg;

  // --------------------
  // Widths
  // --------------------

  // Narrow flit width on the push side
  localparam int push_width = 8;

  // Wide flit width on the pop side
  localparam int pop_width = 32;

  // Sideband metadata, sampled on the completing push flit
  localparam int meta_width = 3;

  // Number of push flits that fill one pop flit
  localparam int ratio = pop_width / push_width;

  // Enough bits to count the push flits inside one pop flit
  localparam int flit_id_width = $clog2(ratio);

  // --------------------
  // Types
  // --------------------

  typedef logic [push_width-1:0]    push_flit_t;
  typedef logic [pop_width-1:0]     pop_flit_t;
  typedef logic [meta_width-1:0]    meta_t;
  typedef logic [flit_id_width-1:0] flit_id_t;

  // Position of the push flit that always completes a full pop flit
  localparam flit_id_t last_flit_id = flit_id_t'(ratio - 1);

  // Controller state; holding marks a completed pop flit that saw back-pressure
  typedef enum logic {
    collecting,
    holding
  } ctrl_state_t;

endpackage

/* deser_slice_if.sv */
// Internal link between the flit controller, slice storage and pop assembly.
// Only the first ratio-1 slices are stored; the last one is always live.

`timescale 1ns/1ns

interface deser_slice_if;

  // Position of the current push flit inside the pop flit being built
  deser_pkg::flit_id_t flit_id;

  // Accepted push flit that does not complete the pop flit
  logic slice_load;

  // Push flit is valid and marks the end of the packet
  logic closing;

  // Live push data straight from the top-level port
  deser_pkg::push_flit_t push_data;

  // Staged slices, indexed by flit position
  deser_pkg::push_flit_t [deser_pkg::ratio-2:0] stored;

  // The controller owns the position and the load strobes
  modport ctrl (
    output flit_id,
    output slice_load,
    output closing
  );

  // Storage captures push data into the slot picked by flit_id
  modport store (
    input  flit_id,
    input  slice_load,
    input  push_data,
    output stored
  );

  // Assembly merges the stored slots with the live flit
  modport assemble (
    input flit_id,
    input closing,
    input push_data,
    input stored
  );

endinterface

/* deser_flit_ctrl.sv */
// Flit-position counter and handshake control for the deserializer.
// The push flit, push_last and metadata must stay stable while push_valid
// is high and push_ready is low. The pop flit completes with zero latency.

`timescale 1ns/1ns

module deser_flit_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                push_valid,
  input  logic                push_last,
  input  logic                pop_ready,
  output logic                push_ready,
  output logic                pop_valid,
  output deser_pkg::flit_id_t pop_last_dont_care_count,
  deser_slice_if.ctrl         bus
);

  deser_pkg::flit_id_t    flit_id_q;
  deser_pkg::ctrl_state_t state_q;
  deser_pkg::ctrl_state_t state_d;
  logic                   completing;
  logic                   push_accept;
  logic                   pop_accept;

  // --------------------
  // Handshake decode
  // --------------------

  // A pop flit completes when its last slot arrives or the packet ends early
  assign completing = push_valid && (push_last || (flit_id_q == deser_pkg::last_flit_id));

  assign pop_valid = completing;

  // Non-completing flits go straight into storage, so they are always taken.
  // A completing flit has to wait for the pop side to take the wide flit
  assign push_ready = pop_ready || (!completing && (state_q == deser_pkg::collecting));

  assign push_accept = push_valid && push_ready;
  assign pop_accept  = pop_valid && pop_ready;

  // Drive the shared interface
  assign bus.flit_id    = flit_id_q;
  assign bus.closing    = push_valid && push_last;
  assign bus.slice_load = push_accept && !completing;

  // Slots past the closing flit carry stale data and are flagged here
  assign pop_last_dont_care_count = bus.closing ?
                                    deser_pkg::flit_id_t'(deser_pkg::last_flit_id - flit_id_q) :
                                    '0;

  // --------------------
  // Position counter
  // --------------------

  // A pop transfer starts the next pop flit at slot zero.
  // Otherwise each accepted push moves one slot on
  always_ff @(posedge clk) begin
    if (reset) begin
      flit_id_q <= '0;
    end else if (pop_accept) begin
      flit_id_q <= '0;
    end else if (push_accept) begin
      flit_id_q <= flit_id_q + 1'b1;
    end
  end

  // --------------------
  // Back-pressure state
  // --------------------

  // Holding tracks a completed pop flit that is stalled by pop_ready
  always_comb begin
    state_d = state_q;
    case (state_q)
      deser_pkg::collecting: begin
        if (pop_valid && !pop_ready) begin
          state_d = deser_pkg::holding;
        end
      end
      deser_pkg::holding: begin
        // Leave once the stalled flit is taken or is no longer offered
        if (pop_ready || !pop_valid) begin
          state_d = deser_pkg::collecting;
        end
      end
      default: begin
        state_d = deser_pkg::collecting;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= deser_pkg::collecting;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* deser_slice_store.sv */
// Staging registers for every slice of the pop flit except the last.
// Each register loads only when its slot is selected, with no shifting.

`timescale 1ns/1ns

module deser_slice_store (
  input  logic         clk,
  input  logic         reset,
  deser_slice_if.store bus
);

  // One register per stored slot
  deser_pkg::push_flit_t [deser_pkg::ratio-2:0] slice_q;

  // --------------------
  // Demux into registers
  // --------------------

  // The flit position picks which slot takes the incoming push data.
  // A closing flit is never stored because assembly uses it live
  always_ff @(posedge clk) begin
    if (reset) begin
      slice_q <= '0;
    end else begin
      for (int i = 0; i < deser_pkg::ratio - 1; i++) begin
        if (bus.slice_load && (bus.flit_id == deser_pkg::flit_id_t'(i))) begin
          slice_q[i] <= bus.push_data;
        end
      end
    end
  end

  // Slots that were not written in this pop flit keep older data
  assign bus.stored = slice_q;

endmodule

/* deser_pop_assemble.sv */
// Combinational build of the wide pop word from stored and live slices.
// msb_first=1 puts slot 0 in the top byte, msb_first=0 in the bottom byte.
// Slots after a closing flit show stale register contents.

`timescale 1ns/1ns

module deser_pop_assemble #(
  parameter bit msb_first = 1'b1
) (
  output deser_pkg::pop_flit_t pop_data,
  deser_slice_if.assemble      bus
);

  // --------------------
  // Slot placement
  // --------------------

  for (genvar i = 0; i < deser_pkg::ratio; i++) begin : g_slot
    // Bit offset of slot i inside the pop word
    localparam int lsb = msb_first ? (deser_pkg::ratio - 1 - i) * deser_pkg::push_width :
                                     i * deser_pkg::push_width;

    if (i < deser_pkg::ratio - 1) begin : g_stored
      logic live;

      // A closing flit lands in its own slot directly, with no register in between
      assign live = bus.closing && (bus.flit_id == deser_pkg::flit_id_t'(i));

      assign pop_data[lsb +: deser_pkg::push_width] = live ? bus.push_data : bus.stored[i];
    end else begin : g_last
      // The last slot is only ever filled by the flit that completes the word
      assign pop_data[lsb +: deser_pkg::push_width] = bus.push_data;
    end
  end

endmodule

/* deser_top.sv */
// Flit deserializer top level that packs 8-bit push flits into one 32-bit pop flit.
// Push and pop use valid/ready; a push flit is held until it is accepted.
// push_last closes a pop flit early and pop_last_dont_care_count gives the
// number of unused trailing slots. Metadata is passed through live.

`timescale 1ns/1ns

module deser_top #(
  parameter bit msb_first = 1'b1
) (
  input  logic                  clk,
  input  logic                  reset,

  // Push side, narrow flits
  input  logic                  push_valid,
  output logic                  push_ready,
  input  deser_pkg::push_flit_t push_data,
  input  logic                  push_last,
  input  deser_pkg::meta_t      push_metadata,

  // Pop side, wide flits
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output deser_pkg::pop_flit_t  pop_data,
  output logic                  pop_last,
  output deser_pkg::flit_id_t   pop_last_dont_care_count,
  output deser_pkg::meta_t      pop_metadata
);

  // Shared link between the three blocks
  deser_slice_if u_slice_if ();

  // Live push data feeds both storage and assembly
  assign u_slice_if.push_data = push_data;

  // --------------------
  // Control
  // --------------------

  deser_flit_ctrl u_ctrl (
    .clk                      (clk),
    .reset                    (reset),
    .push_valid               (push_valid),
    .push_last                (push_last),
    .pop_ready                (pop_ready),
    .push_ready               (push_ready),
    .pop_valid                (pop_valid),
    .pop_last_dont_care_count (pop_last_dont_care_count),
    .bus                      (u_slice_if.ctrl)
  );

  // --------------------
  // Datapath
  // --------------------

  deser_slice_store u_store (
    .clk   (clk),
    .reset (reset),
    .bus   (u_slice_if.store)
  );

  deser_pop_assemble #(
    .msb_first (msb_first)
  ) u_assemble (
    .pop_data (pop_data),
    .bus      (u_slice_if.assemble)
  );

  // The pop flit completes in the cycle of its final push flit,
  // so last and metadata come straight from that flit
  assign pop_last     = push_last;
  assign pop_metadata = push_metadata;

endmodule

/* tb_deser_tasks.svh */
// Expected-value and compare helpers that tb_deser includes inside its module body.
// They rely on msb_first, the expected queues and the check counters there.

`ifndef TB_DESER_TASKS_SVH
`define TB_DESER_TASKS_SVH

  // Bit offset of slot k; msb_first puts slot 0 in the top byte
  function automatic int slot_lsb(input int k);
    if (msb_first) begin
      return (deser_pkg::ratio - 1 - k) * deser_pkg::push_width;
    end
    return k * deser_pkg::push_width;
  endfunction

  // Splits one packet into pop flits of up to ratio push flits each
  task automatic build_expected(input int len, input deser_pkg::meta_t meta,
                                input deser_pkg::push_flit_t data [$]);
    deser_pkg::pop_flit_t word;
    deser_pkg::pop_flit_t mask;
    int                   used;
    bit                   last;
    for (int base = 0; base < len; base += deser_pkg::ratio) begin
      word = '0;
      mask = '0;
      used = (len - base < deser_pkg::ratio) ? len - base : deser_pkg::ratio;
      last = (base + deser_pkg::ratio >= len);
      for (int k = 0; k < used; k++) begin
        word[slot_lsb(k) +: deser_pkg::push_width] = data[base + k];
        mask[slot_lsb(k) +: deser_pkg::push_width] = '1;
      end
      exp_data_q.push_back(word);
      exp_mask_q.push_back(mask);
      exp_last_q.push_back(last);
      // Only the final pop flit of a packet can have unused slots
      exp_count_q.push_back(last ? deser_pkg::flit_id_t'(deser_pkg::ratio - used) : '0);
      exp_meta_q.push_back(meta);
    end
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Fail %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic check_condition(input bit ok, input string what);
    check_count++;
    assert (ok) else begin
      $display("Error at %0t: %s", $time, what);
      error_count++;
    end
  endtask

  // Compares one pop transfer with the oldest expected pop flit
  task automatic check_pop();
    deser_pkg::pop_flit_t exp_data;
    deser_pkg::pop_flit_t exp_mask;
    bit                   exp_last;
    deser_pkg::flit_id_t  exp_count;
    deser_pkg::meta_t     exp_meta;
    if (exp_data_q.size() == 0) begin
      check_condition(1'b0, "pop flit transferred while none was expected");
    end else begin
      exp_data  = exp_data_q.pop_front();
      exp_mask  = exp_mask_q.pop_front();
      exp_last  = exp_last_q.pop_front();
      exp_count = exp_count_q.pop_front();
      exp_meta  = exp_meta_q.pop_front();
      // Don't-care slots hold stale data and are masked out
      compare_field("pop_data", pop_data & exp_mask, exp_data);
      compare_field("pop_last", 32'(pop_last), 32'(exp_last));
      compare_field("pop_last_dont_care_count", 32'(pop_last_dont_care_count), 32'(exp_count));
      compare_field("pop_metadata", 32'(pop_metadata), 32'(exp_meta));
    end
    seen_pops++;
    if (pop_last) begin
      seen_last_dc = int'(pop_last_dont_care_count);
    end
  endtask

`endif

/* tb_deser.sv */
// The Makefile runs this flit deserializer testbench once per msb_first setting.
// Push data is random from a fixed seed; pop_ready is either held high or random.
// Outputs are sampled on the falling edge, where all inputs are settled.

`timescale 1ns/1ns

module tb_deser #(
  parameter bit msb_first = 1'b1
);

  localparam int clk_period      = 8;
  localparam int num_rows        = 11;
  localparam int watchdog_factor = 20;

  // --------------------
  // Packet table
  // --------------------

  // Columns are length in push flits, metadata, random pop_ready, then the
  // expected pop flit count and the don't-care count of the final pop flit
  localparam int               row_len      [num_rows] = '{4, 8, 5, 6, 7, 1, 9, 4, 6, 1, 3};
  localparam deser_pkg::meta_t row_meta     [num_rows] = '{3'h1, 3'h2, 3'h3, 3'h4, 3'h5, 3'h6,
                                                           3'h7, 3'h0, 3'h5, 3'h2, 3'h6};
  localparam bit               row_random   [num_rows] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1};
  localparam int               row_exp_pops [num_rows] = '{1, 2, 2, 2, 2, 1, 3, 1, 2, 1, 1};
  localparam int               row_exp_dc   [num_rows] = '{0, 0, 3, 2, 1, 3, 3, 0, 2, 3, 1};

  logic                  clk;
  logic                  reset;
  logic                  push_valid;
  logic                  push_ready;
  deser_pkg::push_flit_t push_data;
  logic                  push_last;
  deser_pkg::meta_t      push_metadata;
  logic                  pop_valid;
  logic                  pop_ready;
  deser_pkg::pop_flit_t  pop_data;
  logic                  pop_last;
  deser_pkg::flit_id_t   pop_last_dont_care_count;
  deser_pkg::meta_t      pop_metadata;

  int seed = 32'hd831;

  // Pop flits still owed by the DUT, oldest first
  deser_pkg::pop_flit_t exp_data_q  [$];
  deser_pkg::pop_flit_t exp_mask_q  [$];
  bit                   exp_last_q  [$];
  deser_pkg::flit_id_t  exp_count_q [$];
  deser_pkg::meta_t     exp_meta_q  [$];

  int check_count  = 0;
  int error_count  = 0;
  int rows_passed  = 0;
  int rows_failed  = 0;
  int seen_pops    = 0;
  int seen_last_dc = 0;

  // Position of the next push flit inside the pop flit, tracked from the handshakes
  int tb_slot = 0;

  deser_top #(
    .msb_first (msb_first)
  ) u_dut (
    .clk                      (clk),
    .reset                    (reset),
    .push_valid               (push_valid),
    .push_ready               (push_ready),
    .push_data                (push_data),
    .push_last                (push_last),
    .push_metadata            (push_metadata),
    .pop_valid                (pop_valid),
    .pop_ready                (pop_ready),
    .pop_data                 (pop_data),
    .pop_last                 (pop_last),
    .pop_last_dont_care_count (pop_last_dont_care_count),
    .pop_metadata             (pop_metadata)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  `include "tb_deser_tasks.svh"

  // Always ready unless the row asks for random back-pressure
  function automatic bit next_ready(input bit random_mode);
    logic [31:0] r;
    if (!random_mode) begin
      return 1'b1;
    end
    r = $random(seed);
    return r[0];
  endfunction

  // --------------------
  // Monitor
  // --------------------

  // A pop flit completes on the fourth push flit or on push_last, in the same cycle
  task automatic check_cycle();
    bit expect_valid;
    expect_valid = push_valid && (push_last || (tb_slot == deser_pkg::ratio - 1));
    compare_field("pop_valid", 32'(pop_valid), 32'(expect_valid));
    if (push_valid && !expect_valid) begin
      check_condition(push_ready === 1'b1, "push_ready low for a flit that only fills a slice");
    end
    if (pop_valid && !pop_ready) begin
      check_condition(push_ready === 1'b0, "push_ready high while a pop flit waits for pop_ready");
    end
    if (pop_valid && pop_ready) begin
      check_pop();
    end
    if (push_valid && push_ready) begin
      tb_slot = expect_valid ? 0 : tb_slot + 1;
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (reset) begin
        tb_slot = 0;
      end else begin
        check_cycle();
      end
    end
  end

  // --------------------
  // Driver
  // --------------------

  // Sends one packet, holding each flit until the DUT takes it
  task automatic run_row(input int r);
    deser_pkg::push_flit_t data [$];
    int  errors_before;
    bit  accepted;
    errors_before = error_count;
    for (int f = 0; f < row_len[r]; f++) begin
      data.push_back(deser_pkg::push_flit_t'($random(seed)));
    end
    build_expected(row_len[r], row_meta[r], data);
    seen_pops    = 0;
    seen_last_dc = 0;
    for (int f = 0; f < row_len[r]; f++) begin
      push_valid    <= 1'b1;
      push_data     <= data[f];
      push_last     <= (f == row_len[r] - 1);
      push_metadata <= row_meta[r];
      pop_ready     <= next_ready(row_random[r]);
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = push_valid && push_ready;
        @(posedge clk);
        if (!accepted) begin
          pop_ready <= next_ready(row_random[r]);
        end
      end
    end
    // The closing push and its pop transfer share one edge, so nothing is left over
    check_condition(exp_data_q.size() == 0, "pop flits of the packet still missing at its end");
    compare_field("row pop flit count", 32'(seen_pops), 32'(row_exp_pops[r]));
    compare_field("pop_last_dont_care_count", 32'(seen_last_dc), 32'(row_exp_dc[r]));
    if (error_count == errors_before) begin
      rows_passed++;
    end else begin
      rows_failed++;
    end
    $display("Row %0d: %0d push flits, meta %h, %s pop_ready, %0d pop flits, %0d errors",
             r, row_len[r], row_meta[r], row_random[r] ? "random" : "steady", seen_pops,
             error_count - errors_before);
  endtask

  initial begin
    reset         = 1'b1;
    push_valid    = 1'b0;
    push_data     = '0;
    push_last     = 1'b0;
    push_metadata = '0;
    pop_ready     = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // The idle DUT holds pop_valid low and push_ready high even while pop_ready is low
    @(negedge clk);
    check_condition(pop_valid === 1'b0, "pop_valid high after reset with no push flit");
    check_condition(push_ready === 1'b1, "push_ready low after reset");
    $display("Idle after reset: %0d errors", error_count);
    @(posedge clk);

    // Rows go back to back with no idle cycle between packets
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    push_valid <= 1'b0;
    push_last  <= 1'b0;

    // The monitor keeps checking pop_valid on the idle cycles after the last packet
    repeat (2) @(negedge clk);

    $display("Summary: %0d rows passed, %0d rows failed, %0d checks, %0d errors",
             rows_passed, rows_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // --------------------
  // Watchdog
  // --------------------

  initial begin : watchdog
    int total_flits;
    total_flits = 0;
    for (int r = 0; r < num_rows; r++) begin
      total_flits += row_len[r];
    end
    repeat (total_flits * watchdog_factor) @(posedge clk);
    $display("Watchdog expired after %0d cycles before all packets were done",
             total_flits * watchdog_factor);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
deser_pkg.sv
deser_slice_if.sv
deser_flit_ctrl.sv
deser_slice_store.sv
deser_pop_assemble.sv
deser_top.sv
tb_deser.sv

/* Makefile */
# Verilator flow for the flit deserializer
# Override on the command line, e.g. make sim MSB_FIRST=0

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_deser
RTL_TOP   ?= deser_top
MSB_FIRST ?= 1
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim regress clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Gmsb_first=$(MSB_FIRST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi

regress:
	$(MAKE) sim MSB_FIRST=1 BUILD_DIR=obj_dir_msb LOG=sim_msb.log
	$(MAKE) sim MSB_FIRST=0 BUILD_DIR=obj_dir_lsb LOG=sim_lsb.log

clean:
	rm -rf $(BUILD_DIR) obj_dir_msb obj_dir_lsb $(LOG) sim_msb.log sim_lsb.log
